//--- source/csi_tx_defines.svh
`ifndef CSI_TX_DEFINES_SVH
`define CSI_TX_DEFINES_SVH

// payload beat geometry
`define CSI_DATA_WIDTH 64
`define CSI_BYTES      8

// extension bits of the virtual channel
`define CSI_VCX_WIDTH  2

`define NUM_PIPES      4

// depth is 1 << FIFO_AWIDTH
`define FIFO_AWIDTH    4

`define DT_YUV422_8B   6'h1E

`endif

//--- source/csi_tx_pkg.sv
`include "csi_tx_defines.svh"

package csi_tx_pkg;

    // one registered IDI input cycle
    typedef struct packed {
        logic                         header_en;
        logic                         data_en;
        logic [5:0]                   data_type;
        // base bits on top, extension bits below
        logic [2+`CSI_VCX_WIDTH-1:0]  virtual_channel;
        logic [15:0]                  word_count;
        logic [`CSI_BYTES-1:0]        bytes_en;
        logic [`CSI_DATA_WIDTH-1:0]   csi_data;
    } idi_beat_t;

    // payload layout of a header entry
    typedef struct packed {
        // ecc and spare bits, zero
        logic [`CSI_DATA_WIDTH-2-`CSI_VCX_WIDTH-6-16-1:0] rsv;
        logic [2+`CSI_VCX_WIDTH-1:0]                      virtual_channel;
        logic [5:0]                                       data_type;
        logic [15:0]                                      word_count;
    } idi_hdr_payload_t;

    // one FIFO entry, header or data
    typedef struct packed {
        logic                       data_en;
        logic                       short_packet_en;
        logic                       footer_en_flag;
        logic                       header_en_flag;
        logic [`CSI_DATA_WIDTH-1:0] payload;
    } idi_entry_t;

endpackage

//--- source/data_mapping.sv
`include "csi_tx_defines.svh"

module data_mapping (
    input  logic                       clk_data,
    input  logic                       rst_n,
    input  logic [5:0]                 data_type,
    input  logic [`CSI_BYTES-1:0]      bytes_en,
    input  logic [`CSI_DATA_WIDTH-1:0] csi_data,
    input  logic                       data_en,
    input  logic                       footer_en_flag,
    output logic [`CSI_DATA_WIDTH-1:0] csi_data_mapped,
    output logic                       data_mapped_en,
    output logic                       mapped_footer
);

    logic [`CSI_DATA_WIDTH-1:0] masked;
    logic [`CSI_DATA_WIDTH-1:0] mapped;

    // drop disabled bytes
    always_comb begin
        for (int b = 0; b < `CSI_BYTES; b++) begin
            masked[b*8 +: 8] = bytes_en[b] ? csi_data[b*8 +: 8] : 8'h00;
        end
    end

    // yuv422 8-bit swaps each byte pair
    always_comb begin
        mapped = masked;
        if (data_type == `DT_YUV422_8B) begin
            for (int p = 0; p < `CSI_BYTES / 2; p++) begin
                mapped[p*16 +: 8]     = masked[p*16 + 8 +: 8];
                mapped[p*16 + 8 +: 8] = masked[p*16 +: 8];
            end
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            data_mapped_en <= 1'b0;
        end else begin
            data_mapped_en <= data_en;
        end
    end

    always_ff @(posedge clk_data) begin
        csi_data_mapped <= mapped;
    end

    // the falling header_en shows up just as the held last beat leaves
    assign mapped_footer = data_mapped_en && footer_en_flag;

endmodule

//--- source/idi_stream_splitter.sv
`include "csi_tx_defines.svh"

module idi_stream_splitter import csi_tx_pkg::*; (
    input  logic                        clk_data,
    input  logic                        rst_n,
    input  logic                        header_en,
    input  logic                        data_en,
    input  logic [5:0]                  data_type,
    input  logic [1:0]                  virtual_channel,
    input  logic [`CSI_VCX_WIDTH-1:0]   virtual_channel_x,
    input  logic [15:0]                 word_count,
    input  logic [`CSI_BYTES-1:0]       bytes_en,
    input  logic [`CSI_DATA_WIDTH-1:0]  csi_data,
    output idi_beat_t                   pipe_beat [`NUM_PIPES]
);

    idi_beat_t  in_beat;
    idi_beat_t  beat_q;
    logic       header_en_q;
    logic       data_en_q;
    logic [1:0] vc_sel;

    always_comb begin
        in_beat.header_en       = header_en;
        in_beat.data_en         = data_en;
        in_beat.data_type       = data_type;
        in_beat.virtual_channel = {virtual_channel, virtual_channel_x};
        in_beat.word_count      = word_count;
        in_beat.bytes_en        = bytes_en;
        in_beat.csi_data        = csi_data;
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            header_en_q <= 1'b0;
            data_en_q   <= 1'b0;
        end else begin
            header_en_q <= header_en;
            data_en_q   <= data_en;
        end
    end

    always_ff @(posedge clk_data) begin
        beat_q <= in_beat;
    end

    // base channel picks the pipe
    assign vc_sel = beat_q.virtual_channel[`CSI_VCX_WIDTH +: 2];

    for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_route
        always_comb begin
            pipe_beat[i]           = beat_q;
            pipe_beat[i].header_en = header_en_q && (vc_sel == 2'(i));
            pipe_beat[i].data_en   = data_en_q && (vc_sel == 2'(i));
        end
    end

    // a packet never changes channel mid-flight
    a_vc_stable: assert property (@(posedge clk_data) disable iff (!rst_n)
        (header_en && $past(header_en)) |->
            ($stable(virtual_channel) && $stable(virtual_channel_x)));

endmodule

//--- source/video_pipe.sv
`include "csi_tx_defines.svh"

module video_pipe import csi_tx_pkg::*; (
    input  logic       clk_data,
    input  logic       rst_n,
    input  idi_beat_t  beat,
    output logic       wr_en,
    output idi_entry_t wr_entry
);

    logic                       header_en_d1;
    logic                       header_en_flag;
    logic                       header_en_flag_d1;
    logic                       footer_en_flag;
    logic                       short_packet_en;
    idi_hdr_payload_t           hdr_d1;
    idi_entry_t                 hdr_entry;
    idi_entry_t                 data_entry;
    logic [`CSI_DATA_WIDTH-1:0] csi_data_mapped;
    logic                       data_mapped_en;
    logic                       mapped_footer;

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            header_en_d1      <= 1'b0;
            header_en_flag_d1 <= 1'b0;
        end else begin
            header_en_d1      <= beat.header_en;
            header_en_flag_d1 <= header_en_flag;
        end
    end

    // packet edges from the header_en level
    assign header_en_flag = beat.header_en && !header_en_d1;
    assign footer_en_flag = !beat.header_en && header_en_d1;

    // header that ends right after it started
    assign short_packet_en = header_en_flag_d1 && footer_en_flag;

    // header fields, lined up with header_en_flag_d1
    always_ff @(posedge clk_data) begin
        hdr_d1.rsv             <= '0;
        hdr_d1.virtual_channel <= beat.virtual_channel;
        hdr_d1.data_type       <= beat.data_type;
        hdr_d1.word_count      <= beat.word_count;
    end

    always_comb begin
        hdr_entry                 = '0;
        hdr_entry.header_en_flag  = 1'b1;
        hdr_entry.short_packet_en = short_packet_en;
        hdr_entry.payload         = hdr_d1;
    end

    always_comb begin
        data_entry                = '0;
        data_entry.data_en        = 1'b1;
        data_entry.footer_en_flag = mapped_footer;
        data_entry.payload        = csi_data_mapped;
    end

    data_mapping u_data_mapping (
        .clk_data        ( clk_data        ),
        .rst_n           ( rst_n           ),
        .data_type       ( beat.data_type  ),
        .bytes_en        ( beat.bytes_en   ),
        .csi_data        ( beat.csi_data   ),
        .data_en         ( beat.data_en    ),
        .footer_en_flag  ( footer_en_flag  ),
        .csi_data_mapped ( csi_data_mapped ),
        .data_mapped_en  ( data_mapped_en  ),
        .mapped_footer   ( mapped_footer   )
    );

    // header wins the write port
    assign wr_en    = header_en_flag_d1 || data_mapped_en;
    assign wr_entry = header_en_flag_d1 ? hdr_entry : data_entry;

    // source rules keep header and data writes apart
    a_no_entry_clash: assert property (@(posedge clk_data) disable iff (!rst_n)
        !(header_en_flag_d1 && data_mapped_en));

endmodule

//--- source/sync_fifo.sv
`include "csi_tx_defines.svh"

module sync_fifo import csi_tx_pkg::*; (
    input  logic       clk_data,
    input  logic       rst_n,
    input  logic       wr_en,
    input  idi_entry_t wr_entry,
    input  logic       pop,
    output idi_entry_t head,
    output logic       empty,
    output logic       overflow
);

    localparam int DEPTH = 1 << `FIFO_AWIDTH;

    idi_entry_t            mem [DEPTH];
    logic [`FIFO_AWIDTH:0] wr_ptr;
    logic [`FIFO_AWIDTH:0] rd_ptr;
    logic                  full;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`FIFO_AWIDTH] != rd_ptr[`FIFO_AWIDTH]) &&
                   (wr_ptr[`FIFO_AWIDTH-1:0] == rd_ptr[`FIFO_AWIDTH-1:0]);

    // show-ahead read
    assign head = mem[rd_ptr[`FIFO_AWIDTH-1:0]];

    always_ff @(posedge clk_data) begin
        if (wr_en && !full) begin
            mem[wr_ptr[`FIFO_AWIDTH-1:0]] <= wr_entry;
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // sticky until reset
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk_data) disable iff (!rst_n)
        pop |-> !empty);

endmodule

//--- source/packet_arbiter.sv
`include "csi_tx_defines.svh"

module packet_arbiter import csi_tx_pkg::*; (
    input  logic                          clk_data,
    input  logic                          rst_n,
    input  idi_entry_t                    head [`NUM_PIPES],
    input  logic [`NUM_PIPES-1:0]         empty,
    input  logic                          pcs_ready,
    output logic [`NUM_PIPES-1:0]         pop,
    output logic                          out_valid,
    output idi_entry_t                    out_entry,
    output logic [$clog2(`NUM_PIPES)-1:0] out_pipe
);

    localparam int PW = $clog2(`NUM_PIPES);

    logic          locked;
    logic [PW-1:0] lock_idx;
    logic [PW-1:0] rr_ptr;
    logic          grant_found;
    logic [PW-1:0] grant_idx;
    logic [PW-1:0] sel_idx;
    logic          sel_valid;
    logic          pop_now;
    logic          pkt_end;
    idi_entry_t    sel_entry;

    // next packet start, searched from the pipe after the last one served
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 1; k <= `NUM_PIPES; k++) begin
            idx = (int'(rr_ptr) + k) % `NUM_PIPES;
            if (!grant_found && !empty[idx] && head[idx].header_en_flag) begin
                grant_found = 1'b1;
                grant_idx   = PW'(idx);
            end
        end
    end

    // stay on the locked pipe, wait if it runs dry
    assign sel_idx   = locked ? lock_idx : grant_idx;
    assign sel_valid = locked ? !empty[lock_idx] : grant_found;
    assign pop_now   = sel_valid && pcs_ready;
    assign sel_entry = head[sel_idx];
    assign pkt_end   = sel_entry.short_packet_en || sel_entry.footer_en_flag;

    always_comb begin
        pop          = '0;
        pop[sel_idx] = pop_now;
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            lock_idx  <= '0;
            rr_ptr    <= PW'(`NUM_PIPES - 1);
            out_valid <= 1'b0;
            out_pipe  <= '0;
        end else begin
            out_valid <= pop_now;
            if (pop_now) begin
                locked   <= !pkt_end;
                lock_idx <= sel_idx;
                rr_ptr   <= sel_idx;
                out_pipe <= sel_idx;
            end
        end
    end

    always_ff @(posedge clk_data) begin
        if (pop_now) begin
            out_entry <= sel_entry;
        end
    end

    // a locked packet runs to its end before any new header
    a_locked_no_header: assert property (@(posedge clk_data) disable iff (!rst_n)
        (locked && pop_now) |-> !sel_entry.header_en_flag);

endmodule

//--- source/csi_tx_idi.sv
`include "csi_tx_defines.svh"

module csi_tx_idi import csi_tx_pkg::*; (
    input  logic                          clk_data,
    input  logic                          rst_n,
    input  logic                          header_en,
    input  logic                          data_en,
    input  logic [5:0]                    data_type,
    input  logic [1:0]                    virtual_channel,
    input  logic [`CSI_VCX_WIDTH-1:0]     virtual_channel_x,
    input  logic [15:0]                   word_count,
    input  logic [`CSI_BYTES-1:0]         bytes_en,
    input  logic [`CSI_DATA_WIDTH-1:0]    csi_data,
    input  logic                          pcs_ready,
    output logic                          out_valid,
    output idi_entry_t                    out_entry,
    output logic [$clog2(`NUM_PIPES)-1:0] out_pipe,
    output logic [`NUM_PIPES-1:0]         overflow
);

    idi_beat_t             pipe_beat [`NUM_PIPES];
    logic [`NUM_PIPES-1:0] wr_en;
    idi_entry_t            wr_entry [`NUM_PIPES];
    idi_entry_t            head [`NUM_PIPES];
    logic [`NUM_PIPES-1:0] empty;
    logic [`NUM_PIPES-1:0] pop;

    idi_stream_splitter u_splitter (
        .clk_data          ( clk_data          ),
        .rst_n             ( rst_n             ),
        .header_en         ( header_en         ),
        .data_en           ( data_en           ),
        .data_type         ( data_type         ),
        .virtual_channel   ( virtual_channel   ),
        .virtual_channel_x ( virtual_channel_x ),
        .word_count        ( word_count        ),
        .bytes_en          ( bytes_en          ),
        .csi_data          ( csi_data          ),
        .pipe_beat         ( pipe_beat         )
    );

    // one pipe and FIFO per base channel
    for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_pipe
        video_pipe u_pipe (
            .clk_data ( clk_data     ),
            .rst_n    ( rst_n        ),
            .beat     ( pipe_beat[i] ),
            .wr_en    ( wr_en[i]     ),
            .wr_entry ( wr_entry[i]  )
        );

        sync_fifo u_fifo (
            .clk_data ( clk_data    ),
            .rst_n    ( rst_n       ),
            .wr_en    ( wr_en[i]    ),
            .wr_entry ( wr_entry[i] ),
            .pop      ( pop[i]      ),
            .head     ( head[i]     ),
            .empty    ( empty[i]    ),
            .overflow ( overflow[i] )
        );
    end

    packet_arbiter u_arbiter (
        .clk_data  ( clk_data  ),
        .rst_n     ( rst_n     ),
        .head      ( head      ),
        .empty     ( empty     ),
        .pcs_ready ( pcs_ready ),
        .pop       ( pop       ),
        .out_valid ( out_valid ),
        .out_entry ( out_entry ),
        .out_pipe  ( out_pipe  )
    );

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_data,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk_data = 1'b0;
        forever #HALF_PERIOD clk_data = ~clk_data;
    end

    // reset held over the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_data);
        #10;
        rst_n = 1'b1;
    end

endmodule

//--- dv/csi_tx_idi_tb.sv
`include "csi_tx_defines.svh"

module csi_tx_idi_tb import csi_tx_pkg::*; ();

    localparam int DEPTH    = 1 << `FIFO_AWIDTH;
    localparam int NUM_ROWS = 13;

    typedef struct packed {
        logic [1:0]                vc;
        logic [`CSI_VCX_WIDTH-1:0] vcx;
        logic [5:0]                dt;
        logic [15:0]               wc;
        logic [7:0]                beats;
        logic [`CSI_BYTES-1:0]     be;
        logic                      bp;
    } row_t;

    typedef struct packed {
        logic [1:0] pipe;
        idi_entry_t entry;
    } exp_rec_t;

    logic                       clk_data;
    logic                       rst_n;
    logic                       header_en;
    logic                       data_en;
    logic [5:0]                 data_type;
    logic [1:0]                 virtual_channel;
    logic [`CSI_VCX_WIDTH-1:0]  virtual_channel_x;
    logic [15:0]                word_count;
    logic [`CSI_BYTES-1:0]      bytes_en;
    logic [`CSI_DATA_WIDTH-1:0] csi_data;
    logic                       pcs_ready;
    logic                       out_valid;
    idi_entry_t                 out_entry;
    logic [1:0]                 out_pipe;
    logic [`NUM_PIPES-1:0]      overflow;

    row_t                  rows [NUM_ROWS];
    exp_rec_t              exp_q [$];
    integer                seed = 32'hfc58;
    logic [`NUM_PIPES-1:0] exp_overflow;
    logic                  ready_at_edge = 1'b1;
    logic                  in_packet;
    logic [1:0]            cur_pipe;

    tb_clock_gen u_clock (
        .clk_data ( clk_data ),
        .rst_n    ( rst_n    )
    );

    csi_tx_idi dut0 (
        .clk_data          ( clk_data          ),
        .rst_n             ( rst_n             ),
        .header_en         ( header_en         ),
        .data_en           ( data_en           ),
        .data_type         ( data_type         ),
        .virtual_channel   ( virtual_channel   ),
        .virtual_channel_x ( virtual_channel_x ),
        .word_count        ( word_count        ),
        .bytes_en          ( bytes_en          ),
        .csi_data          ( csi_data          ),
        .pcs_ready         ( pcs_ready         ),
        .out_valid         ( out_valid         ),
        .out_entry         ( out_entry         ),
        .out_pipe          ( out_pipe          ),
        .overflow          ( overflow          )
    );

    task automatic load_table();
        // vc, vcx, data type, word count, beats (0 = short), bytes_en, back-pressure
        rows[0]  = {2'd0, 2'd0, 6'h2A, 16'd32,  8'd4,  8'hFF, 1'b0};
        rows[1]  = {2'd1, 2'd2, 6'h1E, 16'd24,  8'd3,  8'hFF, 1'b0};
        rows[2]  = {2'd2, 2'd1, 6'h00, 16'h0001, 8'd0, 8'h00, 1'b0};
        rows[3]  = {2'd3, 2'd3, 6'h2B, 16'd40,  8'd5,  8'h0F, 1'b0};
        rows[4]  = {2'd0, 2'd1, 6'h1E, 16'd16,  8'd2,  8'h3C, 1'b0};
        rows[5]  = {2'd1, 2'd0, 6'h01, 16'h0007, 8'd0, 8'h00, 1'b0};
        rows[6]  = {2'd2, 2'd0, 6'h2A, 16'd48,  8'd6,  8'hFF, 1'b0};
        rows[7]  = {2'd3, 2'd2, 6'h1E, 16'd8,   8'd1,  8'hA5, 1'b0};
        rows[8]  = {2'd0, 2'd3, 6'h02, 16'h0003, 8'd0, 8'h00, 1'b0};
        // stalled together, so two full packets compete for the output
        rows[9]  = {2'd2, 2'd3, 6'h1E, 16'd56,  8'd7,  8'hFF, 1'b1};
        rows[10] = {2'd1, 2'd1, 6'h2A, 16'd64,  8'd8,  8'h7F, 1'b1};
        rows[11] = {2'd3, 2'd0, 6'h03, 16'h0002, 8'd0, 8'h00, 1'b0};
        // overfills pipe 0, must stay last
        rows[12] = {2'd0, 2'd2, 6'h2B, 16'd160, 8'd20, 8'hFF, 1'b1};
    endtask

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_entry(input idi_entry_t expected, input idi_entry_t actual);
        if (actual !== expected) begin
            $display("error at %0t: out_entry expected %h got %h", $time, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_pipe(input logic [1:0] expected, input logic [1:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: out_pipe expected %0d got %0d", $time, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_overflow(input logic [`NUM_PIPES-1:0] expected,
                                  input logic [`NUM_PIPES-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: overflow expected %b got %b", $time, expected, actual);
            stop_run();
        end
    endtask

    // output byte b comes from input byte b, or its pair partner for yuv422
    function automatic logic [`CSI_DATA_WIDTH-1:0] map_payload(
        input logic [5:0] dt, input logic [`CSI_BYTES-1:0] be,
        input logic [`CSI_DATA_WIDTH-1:0] data);
        logic [`CSI_DATA_WIDTH-1:0] result;
        int src;
        result = '0;
        for (int b = 0; b < `CSI_BYTES; b++) begin
            src = (dt == `DT_YUV422_8B) ? (b ^ 1) : b;
            if (be[src]) begin
                result[b*8 +: 8] = data[src*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic push_expected(input logic [1:0] pipe, input idi_entry_t e);
        exp_rec_t rec;
        rec.pipe  = pipe;
        rec.entry = e;
        exp_q.push_back(rec);
    endtask

    task automatic next_cycle();
        @(posedge clk_data);
        #10;
    endtask

    task automatic drive_row(input row_t r);
        idi_entry_t                 e;
        logic [`CSI_DATA_WIDTH-1:0] data;
        int                         kept;
        e                 = '0;
        e.header_en_flag  = 1'b1;
        e.short_packet_en = (r.beats == 0);
        e.payload         = `CSI_DATA_WIDTH'({r.vc, r.vcx, r.dt, r.wc});
        push_expected(r.vc, e);
        kept = 1;
        next_cycle();
        header_en         = 1'b1;
        data_en           = 1'b0;
        data_type         = r.dt;
        virtual_channel   = r.vc;
        virtual_channel_x = r.vcx;
        word_count        = r.wc;
        bytes_en          = r.be;
        for (int n = 1; n <= r.beats; n++) begin
            data             = {$random(seed), $random(seed)};
            e                = '0;
            e.data_en        = 1'b1;
            e.footer_en_flag = (n == r.beats);
            e.payload        = map_payload(r.dt, r.be, data);
            // a stalled pipe keeps only what fits in its FIFO
            if (!r.bp || kept < DEPTH) begin
                push_expected(r.vc, e);
                kept++;
            end
            next_cycle();
            data_en  = 1'b1;
            csi_data = data;
        end
        next_cycle();
        header_en = 1'b0;
        data_en   = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_data);
        end
        repeat (2) @(posedge clk_data);
    endtask

    task automatic take_output();
        int       idx;
        exp_rec_t rec;
        idx = -1;
        if (!ready_at_edge) begin
            $display("out_valid was high at %0t after an edge with pcs_ready low", $time);
            stop_run();
        end
        // no other pipe may cut into an open packet
        if (in_packet) begin
            check_pipe(cur_pipe, out_pipe);
        end
        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            if (exp_q[i].pipe == out_pipe) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("an entry came out of pipe %0d at %0t with none expected", out_pipe, $time);
            stop_run();
        end else begin
            rec = exp_q[idx];
            check_entry(rec.entry, out_entry);
            exp_q.delete(idx);
            if (rec.entry.short_packet_en || rec.entry.footer_en_flag) begin
                in_packet = 1'b0;
            end else if (rec.entry.header_en_flag) begin
                in_packet = 1'b1;
                cur_pipe  = out_pipe;
            end
        end
    endtask

    always @(posedge clk_data) begin
        ready_at_edge <= pcs_ready;
    end

    // outputs settle half a cycle after the edge
    always @(negedge clk_data) begin
        if (rst_n && out_valid) begin
            take_output();
        end
    end

    initial begin
        int budget;
        #1;
        budget = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            budget += rows[i].beats + 20;
        end
        #(budget * 4 * 100);
        $display("output stalled, expected entries did not come out in time");
        stop_run();
    end

    initial begin
        header_en         = 1'b0;
        data_en           = 1'b0;
        data_type         = '0;
        virtual_channel   = '0;
        virtual_channel_x = '0;
        word_count        = '0;
        bytes_en          = '0;
        csi_data          = '0;
        pcs_ready         = 1'b1;
        exp_overflow      = '0;
        in_packet         = 1'b0;
        cur_pipe          = '0;
        load_table();
        @(posedge rst_n);
        for (int i = 0; i < NUM_ROWS; i++) begin
            // a run of stalled rows starts from drained FIFOs
            if (rows[i].bp && (i == 0 || !rows[i-1].bp)) begin
                wait_drain();
                next_cycle();
                pcs_ready = 1'b0;
            end
            drive_row(rows[i]);
            if (rows[i].bp && rows[i].beats + 1 > DEPTH) begin
                exp_overflow[rows[i].vc] = 1'b1;
            end
            if (rows[i].bp && (i == NUM_ROWS - 1 || !rows[i+1].bp)) begin
                repeat (2 + ($random(seed) & 15)) next_cycle();
                check_overflow(exp_overflow, overflow);
                pcs_ready = 1'b1;
            end
        end
        wait_drain();
        check_overflow(exp_overflow, overflow);
        if (exp_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d expected entries never came out", exp_q.size());
            stop_run();
        end
    end

endmodule

//--- csi_tx_idi.f
+incdir+source
source/csi_tx_pkg.sv
source/data_mapping.sv
source/idi_stream_splitter.sv
source/video_pipe.sv
source/sync_fifo.sv
source/packet_arbiter.sv
source/csi_tx_idi.sv
dv/tb_clock_gen.sv
dv/csi_tx_idi_tb.sv
